// ==== hw/tetris_macros.svh ====
`ifndef TETRIS_MACROS_SVH
`define TETRIS_MACROS_SVH

// ==============================
// board geometry
// ==============================
`define TETRIS_COLS      10
`define TETRIS_ROWS      24
`define TETRIS_HIDDEN    4    // spawn rows above the field
`define TETRIS_SPAWN_X   4
`define TETRIS_LFSR_SEED 3

// ==============================
// 640x480 timing, in pixels and lines
// ==============================
`define VGA_H_FRONT 16
`define VGA_H_SYNC  96
`define VGA_H_BACK  48
`define VGA_H_ACT   640
`define VGA_V_FRONT 11
`define VGA_V_SYNC  2
`define VGA_V_BACK  32
`define VGA_V_ACT   480

// screen layout
`define SCR_BOARD_X0 245
`define SCR_BOARD_Y0 40
`define SCR_CELL_W   15
`define SCR_CELL_H   20
`define SCR_FRAME    5

// colours, rrggbb
`define COL_PIECE  24'hfe0e86
`define COL_LOCKED 24'h0185fc
`define COL_EMPTY  24'hffffff
`define COL_FRAME  24'h606166
`define COL_BACK   24'h000000

`endif

// ==== hw/tetris_pkg.sv ====
`include "tetris_macros.svh"

package tetris_pkg;

	// code 7 is a second O, kept so the LFSR can use all 3 bits
	typedef enum logic [2:0] {
		SH_O,
		SH_I,
		SH_S,
		SH_Z,
		SH_L,
		SH_J,
		SH_T,
		SH_O_X
	} shape_t;

	typedef logic [1:0] rot_t;

	typedef struct packed {
		shape_t     shape;
		rot_t       rot;
		logic [3:0] col;
		logic [4:0] row;  // 0 is the top hidden row
	} piece_t;

	typedef logic [15:0] piece_mask_t;  // bit row*4+col of the 4x4 box

	typedef logic [`TETRIS_ROWS-1:0][`TETRIS_COLS-1:0] board_t;  // bit 0 is leftmost

	typedef enum logic [2:0] {
		CMD_START,
		CMD_LEFT,
		CMD_RIGHT,
		CMD_ROT_CW,
		CMD_ROT_CCW
	} cmd_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SPAWN,
		ST_FALL,
		ST_LOCK,
		ST_CLEAR,
		ST_OVER
	} game_state_t;

	typedef struct packed {
		game_state_t state;
		logic [6:0]  score;
		logic [6:0]  play_time;
	} game_status_t;

	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
		logic       visible;
	} vga_pos_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

endpackage

// ==== hw/piece_rom.sv ====
`timescale 1ns/1ps

module piece_rom (
	input  tetris_pkg::shape_t      shape,
	input  tetris_pkg::rot_t        rot,
	output tetris_pkg::piece_mask_t mask
);

	// four rotations per shape, rows packed top nibble = box row 3
	localparam tetris_pkg::piece_mask_t mask_table [0:27] = '{
		16'h0033, 16'h0033, 16'h0033, 16'h0033,  // O
		16'h000f, 16'h1111, 16'h000f, 16'h1111,  // I
		16'h0036, 16'h0231, 16'h0036, 16'h0231,  // S
		16'h0063, 16'h0132, 16'h0063, 16'h0132,  // Z
		16'h0074, 16'h0223, 16'h0017, 16'h0311,  // L
		16'h0071, 16'h0322, 16'h0047, 16'h0113,  // J
		16'h0027, 16'h0131, 16'h0072, 16'h0232   // T
	};

	logic [4:0] idx;

	// extra code folds onto O
	always_comb begin
		if (shape == tetris_pkg::SH_O_X) begin
			idx = {tetris_pkg::SH_O, rot};
		end else begin
			idx = {shape, rot};
		end
	end

	assign mask = mask_table[idx];

endmodule

// ==== hw/game_ctrl.sv ====
`timescale 1ns/1ps
`include "tetris_macros.svh"

module game_ctrl #(
	parameter int fall_period = 64
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     cmd_valid,
	input  tetris_pkg::cmd_t         cmd,
	output logic                     cmd_ready,
	input  tetris_pkg::board_t       board,
	input  logic                     clear_done,
	output tetris_pkg::piece_t       piece,
	output logic                     lock_req,
	output tetris_pkg::game_status_t status
);

	localparam int TW = $clog2(fall_period);

	tetris_pkg::game_state_t state;
	tetris_pkg::piece_t      cand;
	tetris_pkg::piece_mask_t cand_mask;
	tetris_pkg::board_t      board_eff;
	logic [TW-1:0]           tick_cnt;
	logic [6:0]              play_time;
	logic                    tick;
	logic                    cmd_fire;
	logic                    from_idle;  // first spawn of a game, board not yet cleared
	logic                    fits;

	piece_rom u_rom (
		.shape(cand.shape),
		.rot  (cand.rot),
		.mask (cand_mask)
	);

	assign tick = (tick_cnt == TW'(fall_period - 1));
	// gravity wins the cycle, a pending command waits
	assign cmd_ready = (state == tetris_pkg::ST_IDLE) || (state == tetris_pkg::ST_OVER) ||
		(state == tetris_pkg::ST_FALL && !tick);
	assign cmd_fire = cmd_valid && cmd_ready;
	assign board_eff = from_idle ? '0 : board;

	// ==============================
	// one candidate position per clk
	// ==============================
	always_comb begin
		cand = piece;
		if (state == tetris_pkg::ST_SPAWN) begin
			cand.shape = tetris_pkg::shape_t'({piece.shape[1], piece.shape[2] ^ piece.shape[0],
				piece.shape[1] ^ piece.shape[0]});  // 3-bit LFSR step
			cand.rot = '0;
			cand.col = 4'(`TETRIS_SPAWN_X);
			cand.row = '0;
		end else if (tick) begin
			cand.row = piece.row + 5'd1;
		end else if (cmd_fire) begin
			case (cmd)
				tetris_pkg::CMD_LEFT:    cand.col = piece.col - 4'd1;  // 0 wraps off the board
				tetris_pkg::CMD_RIGHT:   cand.col = piece.col + 4'd1;
				tetris_pkg::CMD_ROT_CW:  cand.rot = piece.rot + 2'd1;
				tetris_pkg::CMD_ROT_CCW: cand.rot = piece.rot - 2'd1;
				default:                 cand = piece;
			endcase
		end
	end

	// edges and occupied cells
	always_comb begin
		fits = 1'b1;
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 4; c++) begin
				if (cand_mask[r*4+c]) begin
					if (int'(cand.col) + c >= `TETRIS_COLS || int'(cand.row) + r >= `TETRIS_ROWS) begin
						fits = 1'b0;
					end else if (board_eff[int'(cand.row)+r][int'(cand.col)+c]) begin
						fits = 1'b0;
					end
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state     <= tetris_pkg::ST_IDLE;
			piece     <= '{shape: tetris_pkg::shape_t'(`TETRIS_LFSR_SEED), rot: 2'd0,
				col: 4'd0, row: 5'd0};
			lock_req  <= 1'b0;
			tick_cnt  <= '0;
			play_time <= '0;
			from_idle <= 1'b0;
		end else begin
			lock_req  <= 1'b0;
			from_idle <= 1'b0;
			if (state == tetris_pkg::ST_IDLE || tick) begin
				tick_cnt <= '0;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
			if (tick && state != tetris_pkg::ST_IDLE && state != tetris_pkg::ST_OVER) begin
				play_time <= play_time + 7'd1;
			end
			case (state)
				tetris_pkg::ST_IDLE: begin
					if (cmd_fire && cmd == tetris_pkg::CMD_START) begin
						state     <= tetris_pkg::ST_SPAWN;
						from_idle <= 1'b1;
						play_time <= '0;
					end
				end
				tetris_pkg::ST_SPAWN: begin
					piece <= cand;
					state <= fits ? tetris_pkg::ST_FALL : tetris_pkg::ST_OVER;
				end
				tetris_pkg::ST_FALL: begin
					if (tick && !fits) begin
						state    <= tetris_pkg::ST_LOCK;
						lock_req <= 1'b1;
					end else if ((tick || cmd_fire) && fits) begin
						piece <= cand;
					end
				end
				tetris_pkg::ST_LOCK:  state <= tetris_pkg::ST_CLEAR;
				tetris_pkg::ST_CLEAR: if (clear_done) state <= tetris_pkg::ST_SPAWN;
				tetris_pkg::ST_OVER: begin
					if (cmd_fire && cmd == tetris_pkg::CMD_START) state <= tetris_pkg::ST_IDLE;
				end
				default: state <= tetris_pkg::ST_IDLE;
			endcase
		end
	end

	assign status.state     = state;
	assign status.score     = '0;  // merged from board_store at the top
	assign status.play_time = play_time;

	a_col_in_board: assert property (@(posedge clk) disable iff (!rst)
		state == tetris_pkg::ST_FALL |-> piece.col < `TETRIS_COLS);
	a_lock_in_lock: assert property (@(posedge clk) disable iff (!rst)
		lock_req |-> state == tetris_pkg::ST_LOCK);

endmodule

// ==== hw/board_store.sv ====
`timescale 1ns/1ps
`include "tetris_macros.svh"

module board_store (
	input  logic                    clk,
	input  logic                    rst,
	input  tetris_pkg::game_state_t state,
	input  tetris_pkg::piece_t      piece,
	input  logic                    lock_req,
	output tetris_pkg::board_t      board,
	output logic                    clear_done,
	output logic [6:0]              score
);

	tetris_pkg::board_t      shadow;  // compacted copy built during the scan
	tetris_pkg::game_state_t prev_state;
	tetris_pkg::piece_mask_t mask;
	logic [4:0]              scan_row;
	logic [4:0]              dst_row;
	logic                    scan_busy;
	logic                    copy_pend;
	logic                    new_game;
	logic                    row_full;

	piece_rom u_rom (
		.shape(piece.shape),
		.rot  (piece.rot),
		.mask (mask)
	);

	assign new_game = (state == tetris_pkg::ST_SPAWN) && (prev_state == tetris_pkg::ST_IDLE);
	assign row_full = &board[scan_row];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			board      <= '0;
			prev_state <= tetris_pkg::ST_IDLE;
			scan_row   <= '0;
			dst_row    <= '0;
			scan_busy  <= 1'b0;
			copy_pend  <= 1'b0;
			clear_done <= 1'b0;
			score      <= '0;
		end else begin
			prev_state <= state;
			clear_done <= 1'b0;
			if (new_game) begin
				board <= '0;
				score <= '0;
			end else if (lock_req) begin
				for (int r = 0; r < 4; r++) begin
					for (int c = 0; c < 4; c++) begin
						if (mask[r*4+c] && int'(piece.row) + r < `TETRIS_ROWS &&
							int'(piece.col) + c < `TETRIS_COLS) begin
							board[int'(piece.row)+r][int'(piece.col)+c] <= 1'b1;
						end
					end
				end
				scan_busy <= 1'b1;
				scan_row  <= 5'(`TETRIS_ROWS - 1);
				dst_row   <= 5'(`TETRIS_ROWS - 1);
			end else if (scan_busy) begin
				if (row_full) begin
					score <= score + 7'd1;
				end else begin
					dst_row <= dst_row - 5'd1;
				end
				if (scan_row == '0) begin
					scan_busy <= 1'b0;
					copy_pend <= 1'b1;
				end else begin
					scan_row <= scan_row - 5'd1;
				end
			end else if (copy_pend) begin
				board      <= shadow;  // one clk after the last row
				copy_pend  <= 1'b0;
				clear_done <= 1'b1;
			end
		end
	end

	// rows that survive drop to the next free shadow row
	always_ff @(posedge clk) begin
		if (lock_req) begin
			shadow <= '0;
		end else if (scan_busy && !row_full) begin
			shadow[dst_row] <= board[scan_row];
		end
	end

	a_no_lock_in_scan: assert property (@(posedge clk) disable iff (!rst)
		lock_req |-> !scan_busy && !copy_pend);

endmodule

// ==== hw/vga_timing.sv ====
`timescale 1ns/1ps
`include "tetris_macros.svh"

module vga_timing (
	input  logic                 clk,
	input  logic                 rst,
	output logic                 pixel_en,
	output tetris_pkg::vga_pos_t pos,
	output logic                 hsync,
	output logic                 vsync,
	output logic                 blank_n
);

	localparam int H_BLANK = `VGA_H_FRONT + `VGA_H_SYNC + `VGA_H_BACK;
	localparam int H_TOTAL = H_BLANK + `VGA_H_ACT;  // 800
	localparam int V_BLANK = `VGA_V_FRONT + `VGA_V_SYNC + `VGA_V_BACK;
	localparam int V_TOTAL = V_BLANK + `VGA_V_ACT;  // 525

	logic [9:0] h_cnt;
	logic [9:0] v_cnt;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pixel_en <= 1'b0;
			h_cnt    <= '0;
			v_cnt    <= '0;
		end else begin
			pixel_en <= ~pixel_en;  // half rate pixel
			if (pixel_en) begin
				if (h_cnt == 10'(H_TOTAL - 1)) begin
					h_cnt <= '0;
					v_cnt <= (v_cnt == 10'(V_TOTAL - 1)) ? '0 : v_cnt + 10'd1;
				end else begin
					h_cnt <= h_cnt + 10'd1;
				end
			end
		end
	end

	// sync pulses sit right after the front porch
	assign hsync = !(h_cnt >= `VGA_H_FRONT && h_cnt < `VGA_H_FRONT + `VGA_H_SYNC);
	assign vsync = !(v_cnt >= `VGA_V_FRONT && v_cnt < `VGA_V_FRONT + `VGA_V_SYNC);

	assign pos.visible = (h_cnt >= H_BLANK) && (v_cnt >= V_BLANK);
	assign pos.x       = pos.visible ? h_cnt - 10'(H_BLANK) : '0;
	assign pos.y       = pos.visible ? v_cnt - 10'(V_BLANK) : '0;
	assign blank_n     = pos.visible;

	a_cnt_range: assert property (@(posedge clk) disable iff (!rst)
		h_cnt < H_TOTAL && v_cnt < V_TOTAL);

endmodule

// ==== hw/pixel_render.sv ====
`timescale 1ns/1ps
`include "tetris_macros.svh"

module pixel_render (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    pixel_en,
	input  tetris_pkg::vga_pos_t    pos,
	input  tetris_pkg::piece_t      piece,
	input  tetris_pkg::board_t      board,
	input  tetris_pkg::game_state_t state,
	output tetris_pkg::rgb_t        rgb
);

	localparam int BX0 = `SCR_BOARD_X0;
	localparam int BY0 = `SCR_BOARD_Y0;
	localparam int BX1 = BX0 + `TETRIS_COLS * `SCR_CELL_W;                     // 395
	localparam int BY1 = BY0 + (`TETRIS_ROWS - `TETRIS_HIDDEN) * `SCR_CELL_H;  // 440

	tetris_pkg::piece_mask_t mask;
	tetris_pkg::rgb_t        next_rgb;
	logic [9:0]              bx, by;
	logic [3:0]              cell_col, sub_x;
	logic [4:0]              cell_row, sub_y, brow;
	logic [4:0]              dr, dc;
	logic                    in_board, in_frame, piece_hit, locked_hit;

	piece_rom u_rom (
		.shape(piece.shape),
		.rot  (piece.rot),
		.mask (mask)
	);

	assign in_board = pos.visible && pos.x >= BX0 && pos.x < BX1 && pos.y >= BY0 && pos.y < BY1;
	assign in_frame = pos.visible && pos.x >= BX0 - `SCR_FRAME && pos.x < BX1 + `SCR_FRAME &&
		pos.y >= BY0 - `SCR_FRAME && pos.y < BY1 + `SCR_FRAME;

	assign bx       = pos.x - 10'(BX0);
	assign by       = pos.y - 10'(BY0);
	assign cell_col = 4'(bx / `SCR_CELL_W);
	assign sub_x    = 4'(bx % `SCR_CELL_W);
	assign cell_row = 5'(by / `SCR_CELL_H);
	assign sub_y    = 5'(by % `SCR_CELL_H);
	assign brow     = cell_row + 5'(`TETRIS_HIDDEN);  // hidden rows are never on screen

	// offset inside the piece box, negatives wrap above 3
	assign dr = brow - piece.row;
	assign dc = {1'b0, cell_col} - {1'b0, piece.col};

	assign piece_hit  = (state == tetris_pkg::ST_FALL) && dr < 5'd4 && dc < 5'd4 &&
		mask[{dr[1:0], dc[1:0]}];
	assign locked_hit = brow < `TETRIS_ROWS && cell_col < `TETRIS_COLS &&
		board[brow][cell_col] && sub_x != '0 && sub_y != '0;  // gap on first row and column

	always_comb begin
		if (in_board) begin
			if (piece_hit) next_rgb = tetris_pkg::rgb_t'(`COL_PIECE);
			else if (locked_hit) next_rgb = tetris_pkg::rgb_t'(`COL_LOCKED);
			else next_rgb = tetris_pkg::rgb_t'(`COL_EMPTY);
		end else if (in_frame) begin
			next_rgb = tetris_pkg::rgb_t'(`COL_FRAME);
		end else begin
			next_rgb = tetris_pkg::rgb_t'(`COL_BACK);
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) rgb <= '0;
		else if (pixel_en) rgb <= next_rgb;
	end

endmodule

// ==== hw/tetris_top.sv ====
`timescale 1ns/1ps

module tetris_top #(
	parameter int fall_period = 64
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     cmd_valid,
	output logic                     cmd_ready,
	input  tetris_pkg::cmd_t         cmd,
	output tetris_pkg::game_status_t status,
	output logic                     hsync,
	output logic                     vsync,
	output logic                     blank_n,
	output logic                     pixel_en,
	output tetris_pkg::rgb_t         rgb
);

	tetris_pkg::game_status_t ctrl_status;
	tetris_pkg::board_t       board;
	tetris_pkg::piece_t       piece;
	tetris_pkg::vga_pos_t     pos;
	logic                     lock_req;
	logic                     clear_done;
	logic [6:0]               score;

	game_ctrl #(.fall_period(fall_period)) u_ctrl (
		.clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd(cmd), .cmd_ready(cmd_ready),
		.board(board), .clear_done(clear_done), .piece(piece), .lock_req(lock_req),
		.status(ctrl_status)
	);

	board_store u_board (
		.clk(clk), .rst(rst), .state(ctrl_status.state), .piece(piece), .lock_req(lock_req),
		.board(board), .clear_done(clear_done), .score(score)
	);

	vga_timing u_vga (
		.clk(clk), .rst(rst), .pixel_en(pixel_en), .pos(pos), .hsync(hsync), .vsync(vsync),
		.blank_n(blank_n)
	);

	pixel_render u_render (
		.clk(clk), .rst(rst), .pixel_en(pixel_en), .pos(pos), .piece(piece), .board(board),
		.state(ctrl_status.state), .rgb(rgb)
	);

	// score lives with the board
	assign status = '{state: ctrl_status.state, score: score, play_time: ctrl_status.play_time};

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
	parameter int half_period = 4,
	parameter int rst_cycles  = 4
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	// reset low for a few edges, released just after an edge
	initial begin
		rst = 1'b0;
		repeat (rst_cycles) @(posedge clk);
		#1 rst = 1'b1;
	end

endmodule

// ==== tb/tb_board_model.svh ====
`ifndef TB_BOARD_MODEL_SVH
`define TB_BOARD_MODEL_SVH

// ==============================
// reference model of the board
// ==============================
tetris_pkg::board_t model_board;
tetris_pkg::shape_t model_shape = tetris_pkg::shape_t'(`TETRIS_LFSR_SEED);
int                 model_score;
logic [31:0]        lcg_state = 32'd11210;

// masks in spawn orientation with the top box row in the low nibble
function automatic logic [15:0] spawn_mask(input tetris_pkg::shape_t s);
	case (s)
		tetris_pkg::SH_I: return 16'h000f;
		tetris_pkg::SH_S: return 16'h0036;
		tetris_pkg::SH_Z: return 16'h0063;
		tetris_pkg::SH_L: return 16'h0074;
		tetris_pkg::SH_J: return 16'h0071;
		tetris_pkg::SH_T: return 16'h0027;
		default:          return 16'h0033;  // O and the spare code
	endcase
endfunction

// the seven-code shape cycle that starts from the seed
function automatic tetris_pkg::shape_t step_shape(input tetris_pkg::shape_t s);
	case (s)
		tetris_pkg::SH_T:   return tetris_pkg::SH_O_X;
		tetris_pkg::SH_O_X: return tetris_pkg::SH_L;
		tetris_pkg::SH_L:   return tetris_pkg::SH_S;
		tetris_pkg::SH_S:   return tetris_pkg::SH_J;
		tetris_pkg::SH_J:   return tetris_pkg::SH_I;
		tetris_pkg::SH_I:   return tetris_pkg::SH_Z;
		default:            return tetris_pkg::SH_T;  // Z closes the cycle
	endcase
endfunction

function automatic bit shape_fits(input tetris_pkg::shape_t s, input int col, input int row);
	logic [15:0] m;
	m = spawn_mask(s);
	for (int i = 0; i < 16; i++) begin
		if (m[i]) begin
			if (col + i % 4 >= `TETRIS_COLS || row + i / 4 >= `TETRIS_ROWS) return 1'b0;
			if (model_board[row + i / 4][col + i % 4]) return 1'b0;
		end
	end
	return 1'b1;
endfunction

function automatic int shape_width(input tetris_pkg::shape_t s);
	logic [15:0] m;
	int          w;
	m = spawn_mask(s);
	w = 0;
	for (int i = 0; i < 16; i++) begin
		if (m[i] && i % 4 + 1 > w) w = i % 4 + 1;
	end
	return w;
endfunction

function automatic void model_new_game();
	model_board = '0;
	model_score = 0;
endfunction

// steps to the next shape and tells whether it fits at the spawn point
function automatic bit model_spawn();
	model_shape = step_shape(model_shape);
	return shape_fits(model_shape, `TETRIS_SPAWN_X, 0);
endfunction

// straight drop at col then lock and remove full rows
task automatic model_drop(input int col);
	tetris_pkg::board_t settled;
	logic [15:0]        m;
	int                 row;
	int                 dst;
	row = 0;
	while (shape_fits(model_shape, col, row + 1)) row++;
	m = spawn_mask(model_shape);
	for (int i = 0; i < 16; i++) begin
		if (m[i]) model_board[row + i / 4][col + i % 4] = 1'b1;
	end
	settled = '0;
	dst = `TETRIS_ROWS - 1;
	for (int r = `TETRIS_ROWS - 1; r >= 0; r--) begin
		if (&model_board[r]) begin
			model_score++;
		end else begin
			settled[dst] = model_board[r];
			dst--;
		end
	end
	model_board = settled;
endtask

function automatic int lcg_next();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return int'(lcg_state[30:16]);
endfunction

// random target column that falls back to spawn when the path may be blocked
function automatic int model_target();
	int target;
	int lo;
	int hi;
	target = lcg_next() % (`TETRIS_COLS + 1 - shape_width(model_shape));
	lo = (target < `TETRIS_SPAWN_X) ? target : `TETRIS_SPAWN_X;
	hi = (target > `TETRIS_SPAWN_X) ? target : `TETRIS_SPAWN_X;
	for (int c = lo; c <= hi; c++) begin
		// one gravity step may land during the moves
		if (!shape_fits(model_shape, c, 0) || !shape_fits(model_shape, c, 1)) begin
			return `TETRIS_SPAWN_X;
		end
	end
	return target;
endfunction

`endif

// ==== tb/tb_tetris.sv ====
`timescale 1ns/1ps
`include "tetris_macros.svh"

module tb_tetris;

	localparam int FALL    = 64;
	localparam int H_CLKS  = 2 * (`VGA_H_FRONT + `VGA_H_SYNC + `VGA_H_BACK + `VGA_H_ACT);
	localparam int V_LINES = `VGA_V_FRONT + `VGA_V_SYNC + `VGA_V_BACK + `VGA_V_ACT;
	localparam int BOTTOM_Y = `SCR_BOARD_Y0 + 19 * `SCR_CELL_H + 10;  // middle of row 23

	logic                     clk;
	logic                     rst;
	logic                     cmd_valid;
	logic                     cmd_ready;
	tetris_pkg::cmd_t         cmd;
	tetris_pkg::game_status_t status;
	logic                     hsync;
	logic                     vsync;
	logic                     blank_n;
	logic                     pixel_en;
	tetris_pkg::rgb_t         rgb;

	int               errors = 0;
	int               test_errors = 0;
	int               tests = 0;
	int               failed_tests = 0;
	bit               aborted = 1'b0;
	tetris_pkg::rgb_t line_rgb [0:`VGA_H_ACT-1];

	`include "tb_board_model.svh"

	tb_clock u_clock (.clk(clk), .rst(rst));

	tetris_top #(.fall_period(FALL)) u_dut (
		.clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd(cmd),
		.status(status), .hsync(hsync), .vsync(vsync), .blank_n(blank_n),
		.pixel_en(pixel_en), .rgb(rgb)
	);

	// ==============================
	// helpers and checks
	// ==============================
	task automatic next_cycle();
		@(posedge clk);
		#1;  // drive and sample just after the edge
	endtask

	task automatic report_error(input string msg);
		$display("error: %s", msg);
		test_errors++;
	endtask

	task automatic report_timeout(input string what);
		report_error($sformatf("timed out waiting for %s", what));
		aborted = 1'b1;
	endtask

	function automatic tetris_pkg::game_status_t status_of(input tetris_pkg::game_state_t st,
		input int score, input int play_time);
		tetris_pkg::game_status_t s;
		s.state     = st;
		s.score     = 7'(score);
		s.play_time = 7'(play_time);
		return s;
	endfunction

	task automatic check_status(input string name, input tetris_pkg::game_status_t exp,
		input tetris_pkg::game_status_t act, input bit with_time);
		if (act.state !== exp.state || act.score !== exp.score ||
			(with_time && act.play_time !== exp.play_time)) begin
			$display("mismatch %s: expected %s score %0d time %0d, actual %s score %0d time %0d",
				name, exp.state.name(), exp.score, exp.play_time,
				act.state.name(), act.score, act.play_time);
			test_errors++;
		end
	endtask

	task automatic check_rgb(input string name, input tetris_pkg::rgb_t exp,
		input tetris_pkg::rgb_t act);
		if (act !== exp) begin
			$display("mismatch %s: expected %06h actual %06h", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act !== exp) begin
			$display("mismatch %s: expected %0d actual %0d", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		errors += test_errors;
		if (test_errors == 0) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: failed with %0d errors", name, test_errors);
			failed_tests++;
		end
		test_errors = 0;
	endtask

	task automatic wait_state(input tetris_pkg::game_state_t st, input int limit,
		input string what);
		int n;
		n = 0;
		while (status.state !== st && n < limit) begin
			next_cycle();
			n++;
		end
		if (status.state !== st) report_timeout($sformatf("%s in %s", st.name(), what));
	endtask

	// hold valid until the transfer edge
	task automatic send_cmd(input tetris_pkg::cmd_t c);
		int n;
		cmd       = c;
		cmd_valid = 1'b1;
		n = 0;
		while (cmd_ready !== 1'b1 && n < 200) begin
			next_cycle();
			n++;
		end
		if (cmd_ready !== 1'b1) report_timeout($sformatf("cmd_ready for %s", c.name()));
		next_cycle();
		cmd_valid = 1'b0;
	endtask

	function automatic logic sync_value(input int sel);
		case (sel)
			0:       return hsync;
			1:       return vsync;
			default: return blank_n;
		endcase
	endfunction

	task automatic wait_signal(input int sel, input logic level, input string what,
		output int n);
		n = 0;
		while (sync_value(sel) !== level && n < 1_000_000) begin
			next_cycle();
			n++;
		end
		if (sync_value(sel) !== level) report_timeout(what);
	endtask

	task automatic measure_sync(input int sel, output int low, output int period);
		int n;
		wait_signal(sel, 1'b1, "sync high", n);
		wait_signal(sel, 1'b0, "sync fall", n);
		wait_signal(sel, 1'b1, "sync rise", low);
		wait_signal(sel, 1'b0, "next sync fall", n);
		period = low + n;
	endtask

	// rgb of visible line y with one entry per pixel
	task automatic capture_line(input int y);
		int n;
		wait_signal(1, 1'b1, "vsync high", n);
		wait_signal(1, 1'b0, "vsync fall", n);
		for (int k = 0; k <= y; k++) begin
			wait_signal(2, 1'b0, "blanking", n);
			wait_signal(2, 1'b1, "active line", n);
		end
		for (int x = 0; x < `VGA_H_ACT; x++) begin
			repeat (2) next_cycle();  // rgb lags the position by one pixel
			line_rgb[x] = rgb;
		end
	endtask

	// ==============================
	// directed tests
	// ==============================
	task automatic test_reset();
		check_status("reset status", status_of(tetris_pkg::ST_IDLE, 0, 0), status, 1'b1);
		if (cmd_ready !== 1'b1) report_error("cmd_ready is low in idle after reset");
		capture_line(200);
		check_rgb("reset board", tetris_pkg::rgb_t'(`COL_EMPTY), line_rgb[300]);
		check_rgb("reset left frame", tetris_pkg::rgb_t'(`COL_FRAME), line_rgb[242]);
		check_rgb("reset right frame", tetris_pkg::rgb_t'(`COL_FRAME), line_rgb[397]);
		check_rgb("reset background", tetris_pkg::rgb_t'(`COL_BACK), line_rgb[100]);
		finish_test("reset");
	endtask

	task automatic test_sync();
		int   low;
		int   period;
		int   highs;
		logic prev;
		highs = 0;
		prev  = pixel_en;
		for (int i = 0; i < 16; i++) begin
			next_cycle();
			if (pixel_en === prev) report_error("pixel_en kept its level over a clk");
			prev = pixel_en;
			if (pixel_en === 1'b1) highs++;
		end
		check_count("sync pixel_en high clks", 8, highs);
		measure_sync(0, low, period);
		check_count("sync hsync low", 2 * `VGA_H_SYNC, low);
		check_count("sync hsync period", H_CLKS, period);
		measure_sync(1, low, period);
		check_count("sync vsync low", `VGA_V_SYNC * H_CLKS, low);
		check_count("sync vsync period", V_LINES * H_CLKS, period);
		measure_sync(2, low, period);
		check_count("sync blank_n low", 2 * (`VGA_H_FRONT + `VGA_H_SYNC + `VGA_H_BACK), low);
		check_count("sync blank_n period", H_CLKS, period);
		finish_test("sync");
	endtask

	task automatic test_start();
		send_cmd(tetris_pkg::CMD_LEFT);  // ignored in idle
		repeat (3) next_cycle();
		check_status("start idle ignore", status_of(tetris_pkg::ST_IDLE, 0, 0), status, 1'b1);
		send_cmd(tetris_pkg::CMD_START);
		check_status("start spawn", status_of(tetris_pkg::ST_SPAWN, 0, 0), status, 1'b1);
		wait_state(tetris_pkg::ST_FALL, 50, "start");
		finish_test("start");
	endtask

	task automatic test_stack();
		tetris_pkg::game_status_t at_over;
		int                       exp_locks;
		int                       locks;
		int                       n;
		model_new_game();
		exp_locks = 0;
		while (model_spawn()) begin
			model_drop(`TETRIS_SPAWN_X);
			exp_locks++;
		end
		locks = 0;
		n = 0;
		while (status.state !== tetris_pkg::ST_OVER && n < 40 * `TETRIS_ROWS * FALL) begin
			if (status.state === tetris_pkg::ST_LOCK) locks++;
			next_cycle();
			n++;
		end
		if (status.state !== tetris_pkg::ST_OVER) report_timeout("game over in stack");
		check_count("stack locks", exp_locks, locks);
		check_status("stack over", status_of(tetris_pkg::ST_OVER, 0, 0), status, 1'b0);
		at_over = status;
		repeat (4 * FALL) next_cycle();
		check_status("stack time hold", at_over, status, 1'b1);
		finish_test("stack");
	endtask

	task automatic test_guided();
		tetris_pkg::rgb_t exp_rgb;
		bit               alive;
		int               target;
		int               col;
		int               pieces;
		send_cmd(tetris_pkg::CMD_START);  // over back to idle
		send_cmd(tetris_pkg::CMD_START);
		model_new_game();
		alive  = 1'b1;
		pieces = 0;
		while (alive && !aborted && pieces < 300) begin
			alive = model_spawn();
			if (alive) begin
				wait_state(tetris_pkg::ST_FALL, 200, "guided spawn");
				target = model_target();
				col    = `TETRIS_SPAWN_X;
				while (col != target && !aborted) begin
					send_cmd((col < target) ? tetris_pkg::CMD_RIGHT : tetris_pkg::CMD_LEFT);
					col += (col < target) ? 1 : -1;
				end
				model_drop(target);
				wait_state(tetris_pkg::ST_LOCK, 30 * FALL, "guided lock");
				pieces++;
			end
		end
		wait_state(tetris_pkg::ST_OVER, 200, "guided game over");
		check_status("guided score", status_of(tetris_pkg::ST_OVER, model_score, 0), status, 1'b0);
		capture_line(BOTTOM_Y);
		for (int c = 0; c < `TETRIS_COLS; c++) begin
			exp_rgb = model_board[`TETRIS_ROWS-1][c] ? tetris_pkg::rgb_t'(`COL_LOCKED) :
				tetris_pkg::rgb_t'(`COL_EMPTY);
			check_rgb($sformatf("guided bottom row col %0d", c), exp_rgb,
				line_rgb[`SCR_BOARD_X0 + c * `SCR_CELL_W + 7]);
		end
		finish_test("guided");
	endtask

	initial begin
		int n;
		cmd_valid = 1'b0;
		cmd       = tetris_pkg::CMD_START;
		n = 0;
		while (rst !== 1'b1 && n < 20) begin
			@(posedge clk);
			n++;
		end
		if (rst !== 1'b1) report_timeout("reset release");
		next_cycle();
		if (!aborted) test_reset();
		if (!aborted) test_sync();
		if (!aborted) test_start();
		if (!aborted) test_stack();
		if (!aborted) test_guided();
		$display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0 && !aborted) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+hw
+incdir+tb
hw/tetris_pkg.sv
hw/piece_rom.sv
hw/game_ctrl.sv
hw/board_store.sv
hw/vga_timing.sv
hw/pixel_render.sv
hw/tetris_top.sv
tb/tb_clock.sv
tb/tb_tetris.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module tb_tetris --Mdir obj_dir -o sim_tetris
./obj_dir/sim_tetris > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
	exit 1
fi
